/* crate_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module crate_bridge (
    input  logic                   ps_clk,
    input  logic                   rst_i,
    // Crate space slave port
    input  turf_pkg::wb_req_t      wb_req_i,
    output turf_pkg::wb_rsp_t      wb_rsp_o,
    // Link configuration
    input  logic [turf_pkg::NUM_LINKS*turf_pkg::BRIDGE_TYPE_W-1:0] bridge_type_i,
    input  logic [turf_pkg::NUM_LINKS-1:0] aurora_up_i,
    // Command out, response back
    output turf_pkg::bridge_cmd_t  bridge_cmd_o,
    input  turf_pkg::bridge_resp_t bridge_resp_i,
    // Event pulses per link
    output logic [turf_pkg::NUM_LINKS-1:0] timeout_o,
    output logic [turf_pkg::NUM_LINKS-1:0] invalid_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_DONE
    } state_t;

    state_t                               state_q;
    logic                                 req;
    logic [turf_pkg::LINK_W-1:0]          link;
    logic [turf_pkg::BRIDGE_TYPE_W-1:0]   ltype;
    logic                                 type_ok;
    logic                                 ack_q;
    logic                                 err_q;
    logic                                 cmd_vld_q;
    logic [turf_pkg::NUM_LINKS-1:0]       timeout_q;
    logic [turf_pkg::NUM_LINKS-1:0]       invalid_q;
    logic [turf_pkg::BRIDGE_CNT_W-1:0]    cnt_q;
    logic [turf_pkg::WB_DATA_W-1:0]       rdat_q;
    logic                                 cmd_we_q;
    logic [turf_pkg::LINK_W-1:0]          cmd_link_q;
    logic [turf_pkg::CRATE_ADR_W-1:0]     cmd_adr_q;
    logic [turf_pkg::WB_DATA_W-1:0]       cmd_dat_q;

    assign req  = wb_req_i.cyc && wb_req_i.stb;

    ////////////////////
    // Access validation

    // Link field just above the crate address
    assign link  = wb_req_i.adr[turf_pkg::LINK_LSB +: turf_pkg::LINK_W];
    assign ltype = bridge_type_i[link*turf_pkg::BRIDGE_TYPE_W +: turf_pkg::BRIDGE_TYPE_W];

    always_comb begin
        case (ltype)
            // Null bridge always answers
            turf_pkg::BRIDGE_NONE:   type_ok = 1'b1;
            // Aurora needs the link up
            turf_pkg::BRIDGE_AURORA: type_ok = aurora_up_i[link];
            // Reserved codes have no bridge behind them
            default:                 type_ok = 1'b0;
        endcase
    end

    ////////////////////
    // Command FSM

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            state_q   <= ST_IDLE;
            ack_q     <= 1'b0;
            err_q     <= 1'b0;
            cmd_vld_q <= 1'b0;
            timeout_q <= '0;
            invalid_q <= '0;
        end else begin
            // Everything below is a single-cycle pulse
            ack_q     <= 1'b0;
            err_q     <= 1'b0;
            cmd_vld_q <= 1'b0;
            timeout_q <= '0;
            invalid_q <= '0;
            case (state_q)
                ST_IDLE: begin
                    if (req) begin
                        if (!type_ok) begin
                            err_q           <= 1'b1;
                            invalid_q[link] <= 1'b1;
                            state_q         <= ST_DONE;
                        end else if (ltype == turf_pkg::BRIDGE_NONE) begin
                            ack_q   <= 1'b1;
                            state_q <= ST_DONE;
                        end else begin
                            cmd_vld_q <= 1'b1;
                            state_q   <= ST_WAIT;
                        end
                    end
                end
                ST_WAIT: begin
                    // Response beats a same-cycle timeout
                    if (bridge_resp_i.valid) begin
                        ack_q   <= 1'b1;
                        state_q <= ST_DONE;
                    end else if (cnt_q ==
                                 turf_pkg::BRIDGE_CNT_W'(turf_pkg::BRIDGE_TIMEOUT_CYC - 1)) begin
                        err_q                 <= 1'b1;
                        timeout_q[cmd_link_q] <= 1'b1;
                        state_q               <= ST_DONE;
                    end
                end
                // Ack or err is out, master drops stb next
                ST_DONE: state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Payload, counter and read data
    always_ff @(posedge ps_clk) begin
        if (state_q == ST_IDLE) begin
            cnt_q  <= '0;
            // Null bridge reads zero
            rdat_q <= '0;
            if (req) begin
                cmd_we_q   <= wb_req_i.we;
                cmd_link_q <= link;
                cmd_adr_q  <= wb_req_i.adr[turf_pkg::CRATE_ADR_W-1:0];
                cmd_dat_q  <= wb_req_i.dat;
            end
        end else if (state_q == ST_WAIT) begin
            cnt_q <= cnt_q + 1'b1;
            if (bridge_resp_i.valid) begin
                rdat_q <= bridge_resp_i.dat;
            end
        end
    end

    assign wb_rsp_o     = '{ack: ack_q, err: err_q, dat: rdat_q};
    assign bridge_cmd_o = '{valid: cmd_vld_q, we: cmd_we_q, link: cmd_link_q,
                            adr: cmd_adr_q, dat: cmd_dat_q};
    assign timeout_o    = timeout_q;
    assign invalid_o    = invalid_q;

    // Command is a lone pulse
    a_cmd_pulse: assert property (@(posedge ps_clk) disable iff (rst_i)
        bridge_cmd_o.valid |=> !bridge_cmd_o.valid);

    // Only launched from idle, never with one outstanding
    a_cmd_from_idle: assert property (@(posedge ps_clk) disable iff (rst_i)
        bridge_cmd_o.valid |-> $past(state_q) == ST_IDLE);

endmodule

`default_nettype wire

/* flist.f */
turf_pkg.sv
turf_intercon.sv
turf_id_ctrl.sv
crate_bridge.sv
serial_baud_gen.sv
turf_regs_top.sv
tb_clock_gen.sv
tb_turf_regs.sv

/* serial_baud_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module serial_baud_gen (
    input  logic ps_clk,
    input  logic rst_i,
    // 16x baud enables
    output logic hsk_tick_o,
    output logic gps_tick_o
);

    logic [turf_pkg::HSK_ACC_W-1:0] hsk_acc_q;
    logic [turf_pkg::HSK_ACC_W:0]   hsk_sum;
    logic [turf_pkg::GPS_ACC_W-1:0] gps_acc_q;
    logic [turf_pkg::GPS_ACC_W:0]   gps_sum;

    // One extra bit catches the carry
    assign hsk_sum = {1'b0, hsk_acc_q} + {1'b0, turf_pkg::HSK_ADD};
    assign gps_sum = {1'b0, gps_acc_q} + {1'b0, turf_pkg::GPS_ADD};

    // Carry out becomes the tick, remainder stays in
    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            hsk_acc_q  <= '0;
            gps_acc_q  <= '0;
            hsk_tick_o <= 1'b0;
            gps_tick_o <= 1'b0;
        end else begin
            hsk_acc_q  <= hsk_sum[turf_pkg::HSK_ACC_W-1:0];
            gps_acc_q  <= gps_sum[turf_pkg::GPS_ACC_W-1:0];
            hsk_tick_o <= hsk_sum[turf_pkg::HSK_ACC_W];
            gps_tick_o <= gps_sum[turf_pkg::GPS_ACC_W];
        end
    end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic ps_clk,
    output logic rst_o
);

    // 50 MHz processor-side clock
    initial begin
        ps_clk = 1'b0;
        forever #10 ps_clk = ~ps_clk;
    end

    // Reset high for 8 edges, dropped just after the last one
    initial begin
        rst_o = 1'b1;
        repeat (8) @(posedge ps_clk);
        #2;
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

/* tb_turf_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_turf_regs;

    localparam int unsigned CYCLE_LIMIT  = 20000;
    localparam int          ACCESS_LIMIT = 200;
    localparam logic [31:0] SEED         = 32'h5c5106d3;
    // Baud count windows from reset
    localparam int          HSK_WIN      = 1024;
    localparam int          GPS_WIN      = 4096;

    logic                     ps_clk;
    logic                     rst;
    turf_pkg::wb_req_t        wb_req;
    turf_pkg::wb_rsp_t        wb_rsp;
    logic [3:0]               aurora_up;
    turf_pkg::bridge_cmd_t    bridge_cmd;
    turf_pkg::bridge_resp_t   bridge_resp;
    logic                     hsk_tick;
    logic                     gps_tick;

    int unsigned              cycle_cnt = 0;
    int                       err_cnt = 0;
    int                       tests_run = 0;
    int                       tests_failed = 0;
    // Responder delay in cycles where -1 keeps the link silent
    int                       resp_delay = 1;
    int                       cmd_cnt = 0;
    turf_pkg::bridge_cmd_t    last_cmd;
    int unsigned              cmd_cycle = 0;
    int unsigned              done_cycle = 0;
    // Baud tick counts
    int                       hsk_cnt = 0;
    int                       gps_cnt = 0;
    logic                     baud_done = 1'b0;
    // Shadow of the bridge type register
    logic [7:0]               types = 8'h00;

    tb_clock_gen u_clk (
        .ps_clk (ps_clk),
        .rst_o  (rst)
    );

    turf_regs_top u_dut (
        .ps_clk        (ps_clk),
        .rst_i         (rst),
        .wb_req_i      (wb_req),
        .wb_rsp_o      (wb_rsp),
        .aurora_up_i   (aurora_up),
        .bridge_cmd_o  (bridge_cmd),
        .bridge_resp_i (bridge_resp),
        .hsk_tick_o    (hsk_tick),
        .gps_tick_o    (gps_tick)
    );

    always @(posedge ps_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    ////////////////////
    // Reporting helpers

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        err_cnt++;
        $display("Error at %0t: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
    endtask

    task automatic report_failure(input string msg);
        err_cnt++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt != errs_before) begin
            tests_failed++;
            $display("%-14s : %0d error(s)", name, err_cnt - errs_before);
        end else begin
            $display("%-14s : passed", name);
        end
    endtask

    // Place a 2-bit type code in its link's field
    function automatic logic [7:0] set_link_type(input logic [7:0] cur, input logic [1:0] link,
                                                 input logic [1:0] code);
        logic [7:0] mask;
        mask = 8'h03 << (link * 2);
        return (cur & ~mask) | (8'(code) << (link * 2));
    endfunction

    ////////////////////
    // Wishbone master

    // Holds the request until ack or err, drops it one cycle later
    task automatic wb_access(input logic we, input logic [27:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat, output logic err);
        int waited;
        waited = 0;
        @(posedge ps_clk);
        #2;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        wb_req.sel = 4'hF;
        @(negedge ps_clk);
        while (!wb_rsp.ack && !wb_rsp.err && waited < ACCESS_LIMIT) begin
            @(negedge ps_clk);
            waited++;
        end
        done_cycle = cycle_cnt;
        rdat = wb_rsp.dat;
        err  = wb_rsp.err;
        if (!wb_rsp.ack && !wb_rsp.err) begin
            report_failure($sformatf("access to 0x%07h got neither ack nor err", adr));
            err = 1'b1;
        end
        @(posedge ps_clk);
        #2;
        wb_req = '0;
    endtask

    task automatic wb_read(input logic [27:0] adr, output logic [31:0] rdat, output logic err);
        wb_access(1'b0, adr, 32'h0, rdat, err);
    endtask

    task automatic wb_write(input logic [27:0] adr, input logic [31:0] wdat, output logic err);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdat, unused, err);
    endtask

    ////////////////////
    // Crate link model

    // Reads answer with address XOR 0x0BADF00D, writes with zero
    initial begin : crate_responder
        forever begin
            @(negedge ps_clk);
            if (bridge_cmd.valid) begin
                cmd_cnt++;
                last_cmd  = bridge_cmd;
                cmd_cycle = cycle_cnt;
                if (resp_delay >= 1) begin
                    repeat (resp_delay) @(posedge ps_clk);
                    #2;
                    bridge_resp.valid = 1'b1;
                    bridge_resp.dat   = last_cmd.we ? 32'h0 :
                                        ({7'h0, last_cmd.adr} ^ 32'h0BADF00D);
                    @(posedge ps_clk);
                    #2;
                    bridge_resp = '0;
                end
            end
        end
    end

    // Tick counts over the windows right after reset
    initial begin : baud_monitor
        @(negedge rst);
        @(posedge ps_clk);
        for (int i = 0; i < GPS_WIN; i++) begin
            @(negedge ps_clk);
            if (hsk_tick && i < HSK_WIN) begin
                hsk_cnt++;
            end
            if (gps_tick) begin
                gps_cnt++;
            end
        end
        baud_done = 1'b1;
    end

    ////////////////////
    // Directed tests

    task automatic test_identity();
        int          errs;
        logic [31:0] rdat;
        logic        err;
        logic [27:0] adr;
        errs = err_cnt;
        wb_read({14'h0, turf_pkg::ID_REG_IDENT}, rdat, err);
        if (rdat !== 32'h54555246) report_mismatch("ident word", rdat, 32'h54555246);
        // Rev B 0, date 0, version 0.2.0
        wb_read({14'h0, turf_pkg::ID_REG_DATEVER}, rdat, err);
        if (rdat !== 32'h00000200) report_mismatch("date/version", rdat, 32'h00000200);
        // Unmapped space, bits 26:14 nonzero
        adr = {1'b0, 13'($urandom) | 13'h1, 14'($urandom)};
        wb_read(adr, rdat, err);
        if (err !== 1'b0) report_mismatch("default err flag", 32'(err), 32'h0);
        if (rdat !== 32'h0) report_mismatch("default data", rdat, 32'h0);
        finish_test("identity", errs);
    endtask

    task automatic test_bridge_type();
        int          errs;
        logic [31:0] rdat;
        logic        err;
        errs = err_cnt;
        wb_read({14'h0, turf_pkg::ID_REG_BRIDGE_TYPE}, rdat, err);
        if (rdat !== 32'h0) report_mismatch("bridge type after reset", rdat, 32'h0);
        wb_write({14'h0, turf_pkg::ID_REG_BRIDGE_TYPE}, 32'hDEADBE5A, err);
        wb_read({14'h0, turf_pkg::ID_REG_BRIDGE_TYPE}, rdat, err);
        if (rdat !== 32'h5A) report_mismatch("bridge type readback", rdat, 32'h5A);
        wb_write({14'h0, turf_pkg::ID_REG_BRIDGE_TYPE}, 32'h0, err);
        finish_test("bridge type", errs);
    endtask

    task automatic test_aurora_access();
        int          errs;
        int          cmds;
        logic [31:0] rdat;
        logic [31:0] wdat;
        logic        err;
        logic [1:0]  link;
        logic [24:0] cadr;
        errs = err_cnt;
        link = 2'($urandom % 4);
        cadr = 25'($urandom);
        aurora_up = 4'hF;
        types = set_link_type(8'h00, link, 2'd1);
        wb_write({14'h0, turf_pkg::ID_REG_BRIDGE_TYPE}, 32'(types), err);
        // Read through the Aurora bridge
        cmds = cmd_cnt;
        wb_read({1'b1, link, cadr}, rdat, err);
        if (err !== 1'b0) report_mismatch("aurora read err flag", 32'(err), 32'h0);
        if (rdat !== ({7'h0, cadr} ^ 32'h0BADF00D))
            report_mismatch("aurora read data", rdat, {7'h0, cadr} ^ 32'h0BADF00D);
        if (cmd_cnt != cmds + 1) report_mismatch("command count", cmd_cnt, cmds + 1);
        if (last_cmd.link !== link) report_mismatch("command link", 32'(last_cmd.link), 32'(link));
        if (last_cmd.adr !== cadr) report_mismatch("command address", 32'(last_cmd.adr), 32'(cadr));
        if (last_cmd.we !== 1'b0) report_mismatch("command we", 32'(last_cmd.we), 32'h0);
        // Neighbor link left at the null type, right after nonzero read data
        cmds = cmd_cnt;
        wb_read({1'b1, link + 2'd1, cadr}, rdat, err);
        if (err !== 1'b0) report_mismatch("null bridge err flag", 32'(err), 32'h0);
        if (rdat !== 32'h0) report_mismatch("null bridge data", rdat, 32'h0);
        if (cmd_cnt != cmds) report_mismatch("null bridge command count", cmd_cnt, cmds);
        // Write carries its data
        wdat = $urandom;
        wb_write({1'b1, link, cadr}, wdat, err);
        if (err !== 1'b0) report_mismatch("aurora write err flag", 32'(err), 32'h0);
        if (last_cmd.we !== 1'b1) report_mismatch("write command we", 32'(last_cmd.we), 32'h1);
        if (last_cmd.dat !== wdat) report_mismatch("write command data", last_cmd.dat, wdat);
        wb_write({14'h0, turf_pkg::ID_REG_BRIDGE_TYPE}, 32'h0, err);
        finish_test("aurora access", errs);
    endtask

    task automatic test_invalid();
        int          errs;
        int          cmds;
        logic [31:0] rdat;
        logic        err;
        logic [1:0]  link;
        logic [31:0] flag;
        errs = err_cnt;
        link = 2'($urandom % 4);
        flag = 32'h1 << (8 + link);
        cmds = cmd_cnt;
        // Reserved type with the link up
        aurora_up = 4'hF;
        types = set_link_type(8'h00, link, 2'd2);
        wb_write({14'h0, turf_pkg::ID_REG_BRIDGE_TYPE}, 32'(types), err);
        wb_read({1'b1, link, 25'($urandom)}, rdat, err);
        if (err !== 1'b1) report_mismatch("reserved type err flag", 32'(err), 32'h1);
        wb_read({14'h0, turf_pkg::ID_REG_BRIDGE_STAT}, rdat, err);
        if (rdat !== flag) report_mismatch("invalid flag set", rdat, flag);
        wb_write({14'h0, turf_pkg::ID_REG_BRIDGE_STAT}, flag, err);
        wb_read({14'h0, turf_pkg::ID_REG_BRIDGE_STAT}, rdat, err);
        if (rdat !== 32'h0) report_mismatch("invalid flag cleared", rdat, 32'h0);
        // Aurora type with its link down
        aurora_up = ~(4'h1 << link);
        types = set_link_type(8'h00, link, 2'd1);
        wb_write({14'h0, turf_pkg::ID_REG_BRIDGE_TYPE}, 32'(types), err);
        wb_write({1'b1, link, 25'($urandom)}, $urandom, err);
        if (err !== 1'b1) report_mismatch("link down err flag", 32'(err), 32'h1);
        wb_read({14'h0, turf_pkg::ID_REG_BRIDGE_STAT}, rdat, err);
        if (rdat !== flag) report_mismatch("link down invalid flag", rdat, flag);
        wb_write({14'h0, turf_pkg::ID_REG_BRIDGE_STAT}, flag, err);
        if (cmd_cnt != cmds) report_mismatch("commands on invalid access", cmd_cnt, cmds);
        wb_read({14'h0, turf_pkg::ID_REG_LINK_UP}, rdat, err);
        if (rdat !== 32'(aurora_up)) report_mismatch("link up readback", rdat, 32'(aurora_up));
        wb_write({14'h0, turf_pkg::ID_REG_BRIDGE_TYPE}, 32'h0, err);
        finish_test("invalid access", errs);
    endtask

    task automatic test_timeout();
        int          errs;
        logic [31:0] rdat;
        logic        err;
        logic [1:0]  link;
        logic [24:0] cadr;
        errs = err_cnt;
        link = 2'($urandom % 4);
        cadr = 25'($urandom);
        aurora_up = 4'hF;
        types = set_link_type(8'h00, link, 2'd1);
        wb_write({14'h0, turf_pkg::ID_REG_BRIDGE_TYPE}, 32'(types), err);
        // Silent link
        resp_delay = -1;
        wb_read({1'b1, link, cadr}, rdat, err);
        if (err !== 1'b1) report_mismatch("timeout err flag", 32'(err), 32'h1);
        if (done_cycle - cmd_cycle != 64)
            report_mismatch("cycles from command to err", done_cycle - cmd_cycle, 32'd64);
        wb_read({14'h0, turf_pkg::ID_REG_BRIDGE_STAT}, rdat, err);
        if (rdat !== (32'h1 << link)) report_mismatch("timeout flag", rdat, 32'h1 << link);
        wb_write({14'h0, turf_pkg::ID_REG_BRIDGE_STAT}, 32'h1 << link, err);
        // Prompt answer afterwards
        resp_delay = 3;
        wb_read({1'b1, link, cadr}, rdat, err);
        if (err !== 1'b0) report_mismatch("retry err flag", 32'(err), 32'h0);
        if (rdat !== ({7'h0, cadr} ^ 32'h0BADF00D))
            report_mismatch("retry data", rdat, {7'h0, cadr} ^ 32'h0BADF00D);
        resp_delay = 1;
        wb_write({14'h0, turf_pkg::ID_REG_BRIDGE_TYPE}, 32'h0, err);
        finish_test("timeout", errs);
    endtask

    task automatic test_baud();
        int errs;
        int hsk_exp;
        int gps_exp;
        errs = err_cnt;
        // floor(W * ADD / 2^width) for 82/1024 and 25/4096 of the clock
        hsk_exp = (HSK_WIN * 82) / 1024;
        gps_exp = (GPS_WIN * 25) / 4096;
        wait (baud_done);
        if (hsk_cnt > hsk_exp + 1 || hsk_cnt + 1 < hsk_exp)
            report_mismatch("hsk tick count", hsk_cnt, hsk_exp);
        if (gps_cnt > gps_exp + 1 || gps_cnt + 1 < gps_exp)
            report_mismatch("gps tick count", gps_cnt, gps_exp);
        finish_test("baud ticks", errs);
    endtask

    ////////////////////
    // Run control

    initial begin : watchdog
        while (cycle_cnt < CYCLE_LIMIT) @(posedge ps_clk);
        $display("Simulation stopped at the cycle limit of %0d, tests did not finish",
                 CYCLE_LIMIT);
        $display("Test FAILED");
        $finish;
    end

    initial begin : main
        wb_req      = '0;
        bridge_resp = '0;
        aurora_up   = 4'h0;
        void'($urandom(SEED));
        @(negedge rst);
        test_identity();
        test_bridge_type();
        test_aurora_access();
        test_invalid();
        test_timeout();
        test_baud();
        $display("Tests run %0d, tests with errors %0d, total errors %0d",
                 tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* turf_id_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module turf_id_ctrl (
    input  logic                    ps_clk,
    input  logic                    rst_i,
    input  turf_pkg::wb_req_t       wb_req_i,
    output turf_pkg::wb_rsp_t       wb_rsp_o,
    // Link-up levels for readback
    input  logic [turf_pkg::NUM_LINKS-1:0] aurora_up_i,
    // Two bits of bridge type per link
    output logic [turf_pkg::NUM_LINKS*turf_pkg::BRIDGE_TYPE_W-1:0] bridge_type_o,
    // Event pulses from the bridge
    input  logic [turf_pkg::NUM_LINKS-1:0] bridge_timeout_i,
    input  logic [turf_pkg::NUM_LINKS-1:0] bridge_invalid_i
);

    logic                               access;
    logic                               wr_en;
    logic [turf_pkg::ID_OFFS_W-1:0]     offs;
    logic                               ack_q;
    logic [turf_pkg::WB_DATA_W-1:0]     rdat_q;
    logic [turf_pkg::WB_DATA_W-1:0]     rdat;
    logic [turf_pkg::WB_DATA_W-1:0]     stat_word;
    logic [turf_pkg::NUM_LINKS*turf_pkg::BRIDGE_TYPE_W-1:0] bridge_type_q;
    logic [turf_pkg::NUM_LINKS-1:0]     timeout_q;
    logic [turf_pkg::NUM_LINKS-1:0]     invalid_q;
    logic [turf_pkg::NUM_LINKS-1:0]     timeout_clr;
    logic [turf_pkg::NUM_LINKS-1:0]     invalid_clr;

    // New access only while no ack is out
    assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign wr_en  = access && wb_req_i.we;
    assign offs   = wb_req_i.adr[turf_pkg::ID_OFFS_W-1:0];

    ////////////////////
    // Sticky bridge status

    // Write 1 to clear with byte lane 0 for timeouts and lane 1 for invalids
    always_comb begin
        timeout_clr = '0;
        invalid_clr = '0;
        if (wr_en && offs == turf_pkg::ID_REG_BRIDGE_STAT) begin
            if (wb_req_i.sel[0]) begin
                timeout_clr = wb_req_i.dat[3:0];
            end
            if (wb_req_i.sel[1]) begin
                invalid_clr = wb_req_i.dat[11:8];
            end
        end
    end

    // Timeouts low nibble, invalids in 11:8
    always_comb begin
        stat_word       = '0;
        stat_word[3:0]  = timeout_q;
        stat_word[11:8] = invalid_q;
    end

    ////////////////////
    // Read mux

    always_comb begin
        case (offs)
            turf_pkg::ID_REG_IDENT:       rdat = turf_pkg::IDENT_WORD;
            turf_pkg::ID_REG_DATEVER:     rdat = turf_pkg::DATEVERSION;
            turf_pkg::ID_REG_BRIDGE_TYPE: rdat = {24'h0, bridge_type_q};
            turf_pkg::ID_REG_BRIDGE_STAT: rdat = stat_word;
            turf_pkg::ID_REG_LINK_UP:     rdat = {28'h0, aurora_up_i};
            // Holes read zero
            default:                      rdat = '0;
        endcase
    end

    // Control state and writes
    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            ack_q         <= 1'b0;
            bridge_type_q <= {turf_pkg::NUM_LINKS{turf_pkg::BRIDGE_NONE}};
            timeout_q     <= '0;
            invalid_q     <= '0;
        end else begin
            ack_q <= access;
            if (wr_en && offs == turf_pkg::ID_REG_BRIDGE_TYPE && wb_req_i.sel[0]) begin
                bridge_type_q <= wb_req_i.dat[7:0];
            end
            // An event in the clearing cycle still sets the flag
            timeout_q <= bridge_timeout_i | (timeout_q & ~timeout_clr);
            invalid_q <= bridge_invalid_i | (invalid_q & ~invalid_clr);
        end
    end

    // Read data captured with the ack
    always_ff @(posedge ps_clk) begin
        if (access) begin
            rdat_q <= rdat;
        end
    end

    assign wb_rsp_o      = '{ack: ack_q, err: 1'b0, dat: rdat_q};
    assign bridge_type_o = bridge_type_q;

    // Ack only lands while the master still holds its strobe
    a_ack_held: assert property (@(posedge ps_clk) disable iff (rst_i)
        wb_rsp_o.ack |-> wb_req_i.cyc && wb_req_i.stb);

endmodule

`default_nettype wire

/* turf_intercon.sv */
`timescale 1ns/10ps
`default_nettype none

module turf_intercon (
    input  logic              ps_clk,
    input  logic              rst_i,
    // From the PS master
    input  turf_pkg::wb_req_t wb_req_i,
    output turf_pkg::wb_rsp_t wb_rsp_o,
    // ID and control block
    output turf_pkg::wb_req_t id_req_o,
    input  turf_pkg::wb_rsp_t id_rsp_i,
    // Crate register bridge
    output turf_pkg::wb_req_t crate_req_o,
    input  turf_pkg::wb_rsp_t crate_rsp_i
);

    logic crate_sel;
    logic id_sel;
    logic dflt_sel;
    logic dflt_ack_q;

    ////////////////////
    // Address decode

    // Top bit alone claims crate space
    assign crate_sel = wb_req_i.adr[turf_pkg::CRATE_SEL_BIT];

    // ID block only in the lowest 16 kB
    assign id_sel = !crate_sel &&
        (wb_req_i.adr[turf_pkg::CRATE_SEL_BIT-1:turf_pkg::ID_OFFS_W] == '0);

    // Aurora, CIN/COUT and event spaces all land here
    assign dflt_sel = !crate_sel && !id_sel;

    // Whole request fans out, only strobe is steered
    always_comb begin
        id_req_o        = wb_req_i;
        id_req_o.stb    = wb_req_i.stb & id_sel;
        crate_req_o     = wb_req_i;
        crate_req_o.stb = wb_req_i.stb & crate_sel;
    end

    ////////////////////
    // Default responder

    // One-cycle ack, blocked on its own ack so it fires once
    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            dflt_ack_q <= 1'b0;
        end else begin
            dflt_ack_q <= wb_req_i.cyc && wb_req_i.stb && dflt_sel && !dflt_ack_q;
        end
    end

    // Response follows the held address
    always_comb begin
        if (crate_sel) begin
            wb_rsp_o = crate_rsp_i;
        end else if (id_sel) begin
            wb_rsp_o = id_rsp_i;
        end else begin
            wb_rsp_o = '{ack: dflt_ack_q, err: 1'b0, dat: turf_pkg::DEFAULT_DATA};
        end
    end

    // Slaves must never answer both ways at once
    a_ack_err_excl: assert property (@(posedge ps_clk) disable iff (rst_i)
        !(wb_rsp_o.ack && wb_rsp_o.err));

endmodule

`default_nettype wire

/* turf_pkg.sv */
`default_nettype none

package turf_pkg;

    ////////////////////
    // Bus widths

    // Byte address and data of the PS Wishbone
    localparam int WB_ADDR_W   = 28;
    localparam int WB_DATA_W   = 32;
    localparam int WB_SEL_W    = WB_DATA_W / 8;

    // Crate links
    localparam int NUM_LINKS     = 4;
    localparam int LINK_W        = $clog2(NUM_LINKS);
    localparam int CRATE_ADR_W   = 25;
    localparam int BRIDGE_TYPE_W = 2;

    ////////////////////
    // Address map

    // Bit 27 picks crate space
    localparam int CRATE_SEL_BIT = 27;
    // Link field sits just above the crate address
    localparam int LINK_LSB      = CRATE_ADR_W;
    // ID block needs bits 26:14 clear
    localparam int ID_OFFS_W     = 14;

    // ID block word offsets
    localparam logic [ID_OFFS_W-1:0] ID_REG_IDENT       = 14'h00;
    localparam logic [ID_OFFS_W-1:0] ID_REG_DATEVER     = 14'h04;
    localparam logic [ID_OFFS_W-1:0] ID_REG_BRIDGE_TYPE = 14'h08;
    localparam logic [ID_OFFS_W-1:0] ID_REG_BRIDGE_STAT = 14'h0C;
    localparam logic [ID_OFFS_W-1:0] ID_REG_LINK_UP     = 14'h10;

    ////////////////////
    // Identity and version

    // ASCII "TURF"
    localparam logic [WB_DATA_W-1:0] IDENT_WORD = 32'h54555246;

    localparam logic [3:0]  VER_MAJOR     = 4'd0;
    localparam logic [3:0]  VER_MINOR     = 4'd2;
    localparam logic [7:0]  VER_REV       = 8'd0;
    localparam logic [15:0] FIRMWARE_DATE = 16'd0;
    localparam logic        REV_B         = 1'b0;

    // Board rev on top, then date, then the 16-bit version
    localparam logic [WB_DATA_W-1:0] DATEVERSION =
        {REV_B, FIRMWARE_DATE[14:0], VER_MAJOR, VER_MINOR, VER_REV};

    // Readback of the unmapped spaces
    localparam logic [WB_DATA_W-1:0] DEFAULT_DATA = '0;

    // Per-link bridge type codes
    localparam logic [BRIDGE_TYPE_W-1:0] BRIDGE_NONE   = 2'd0;
    localparam logic [BRIDGE_TYPE_W-1:0] BRIDGE_AURORA = 2'd1;
    localparam logic [BRIDGE_TYPE_W-1:0] BRIDGE_RSVD2  = 2'd2;
    localparam logic [BRIDGE_TYPE_W-1:0] BRIDGE_RSVD3  = 2'd3;

    // Response wait, counted from the command pulse
    localparam int BRIDGE_TIMEOUT_CYC = 64;
    localparam int BRIDGE_CNT_W       = $clog2(BRIDGE_TIMEOUT_CYC);

    ////////////////////
    // Baud tick generators

    // 16x housekeeping rate, 82/1024 of ps_clk
    localparam int HSK_ACC_W = 10;
    localparam logic [HSK_ACC_W-1:0] HSK_ADD = 10'd82;
    // 16x GPS rate, 25/4096 of ps_clk
    localparam int GPS_ACC_W = 12;
    localparam logic [GPS_ACC_W-1:0] GPS_ADD = 12'd25;

    ////////////////////
    // Bus bundles

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] dat;
        logic [WB_SEL_W-1:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic                 err;
        logic [WB_DATA_W-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic                   valid;
        logic                   we;
        logic [LINK_W-1:0]      link;
        logic [CRATE_ADR_W-1:0] adr;
        logic [WB_DATA_W-1:0]   dat;
    } bridge_cmd_t;

    typedef struct packed {
        logic                 valid;
        logic [WB_DATA_W-1:0] dat;
    } bridge_resp_t;

endpackage

`default_nettype wire

/* turf_regs_top.sv */
`timescale 1ns/10ps
`default_nettype none

module turf_regs_top (
    input  logic                           ps_clk,
    input  logic                           rst_i,
    // PS Wishbone master
    input  turf_pkg::wb_req_t              wb_req_i,
    output turf_pkg::wb_rsp_t              wb_rsp_o,
    // Aurora link-up levels
    input  logic [turf_pkg::NUM_LINKS-1:0] aurora_up_i,
    // Crate command path
    output turf_pkg::bridge_cmd_t          bridge_cmd_o,
    input  turf_pkg::bridge_resp_t         bridge_resp_i,
    // Serial 16x ticks
    output logic                           hsk_tick_o,
    output logic                           gps_tick_o
);

    turf_pkg::wb_req_t              id_req;
    turf_pkg::wb_rsp_t              id_rsp;
    turf_pkg::wb_req_t              crate_req;
    turf_pkg::wb_rsp_t              crate_rsp;
    // Per-link type, 2 bits each
    logic [turf_pkg::NUM_LINKS*turf_pkg::BRIDGE_TYPE_W-1:0] bridge_type;
    // Bridge event pulses
    logic [turf_pkg::NUM_LINKS-1:0] bridge_timeout;
    logic [turf_pkg::NUM_LINKS-1:0] bridge_invalid;

    ////////////////////
    // Register side

    turf_intercon u_intercon (
        .ps_clk      (ps_clk),
        .rst_i       (rst_i),
        .wb_req_i    (wb_req_i),
        .wb_rsp_o    (wb_rsp_o),
        .id_req_o    (id_req),
        .id_rsp_i    (id_rsp),
        .crate_req_o (crate_req),
        .crate_rsp_i (crate_rsp)
    );

    turf_id_ctrl u_id_ctrl (
        .ps_clk           (ps_clk),
        .rst_i            (rst_i),
        .wb_req_i         (id_req),
        .wb_rsp_o         (id_rsp),
        .aurora_up_i      (aurora_up_i),
        .bridge_type_o    (bridge_type),
        .bridge_timeout_i (bridge_timeout),
        .bridge_invalid_i (bridge_invalid)
    );

    crate_bridge u_bridge (
        .ps_clk        (ps_clk),
        .rst_i         (rst_i),
        .wb_req_i      (crate_req),
        .wb_rsp_o      (crate_rsp),
        .bridge_type_i (bridge_type),
        .aurora_up_i   (aurora_up_i),
        .bridge_cmd_o  (bridge_cmd_o),
        .bridge_resp_i (bridge_resp_i),
        .timeout_o     (bridge_timeout),
        .invalid_o     (bridge_invalid)
    );

    // Free-running serial timing
    serial_baud_gen u_baud (
        .ps_clk     (ps_clk),
        .rst_i      (rst_i),
        .hsk_tick_o (hsk_tick_o),
        .gps_tick_o (gps_tick_o)
    );

endmodule

`default_nettype wire
